/* common/isaPkg.sv */
package isaPkg;

    // RV32I major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opSystem = 7'b1110011
    } opcodeT;

    // branch conditions
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // integer ALU kinds, shared by OP and OP-IMM
    // bit 30 of the word picks sub and sra
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // full ebreak encoding, nothing else in SYSTEM is executed
    localparam logic [31:0] ebreakWord = 32'h0010_0073;

endpackage

/* common/corePkg.sv */
package corePkg;

    // data and address width
    localparam int xlen = 32;

    // one instruction in flight, one state per phase
    typedef enum logic [2:0] {
        fetchIssue,
        fetchWait,
        execute,
        memIssue,
        memWait,
        writeback,
        halted
    } seqStateT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpT;

    // first ALU operand
    typedef enum logic [1:0] {
        srcAReg,
        srcAPc,
        srcAZero
    } srcASelT;

    // second ALU operand
    typedef enum logic {
        srcBReg,
        srcBImm
    } srcBSelT;

    // register writeback source, wbNone leaves the register file alone
    typedef enum logic [1:0] {
        wbAlu,
        wbLoad,
        wbPc4,
        wbNone
    } wbSelT;

endpackage

/* hdl/aluCompare.sv */
`timescale 1ns/1ps

module aluCompare (
    input  corePkg::aluOpT           aluOp,
    input  logic [2:0]               compFunct,
    input  logic [corePkg::xlen-1:0] opA,
    input  logic [corePkg::xlen-1:0] opB,
    input  logic [corePkg::xlen-1:0] cmpA,
    input  logic [corePkg::xlen-1:0] cmpB,
    output logic [corePkg::xlen-1:0] result,
    output logic                     cmpTrue
);

    logic [4:0] shamt;

    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            corePkg::aluAdd:   result = opA + opB;
            corePkg::aluSub:   result = opA - opB;
            corePkg::aluSll:   result = opA << shamt;
            corePkg::aluSlt:   result = corePkg::xlen'($signed(opA) < $signed(opB));
            corePkg::aluSltu:  result = corePkg::xlen'(opA < opB);
            corePkg::aluXor:   result = opA ^ opB;
            corePkg::aluSrl:   result = opA >> shamt;
            corePkg::aluSra:   result = $signed(opA) >>> shamt;
            corePkg::aluOr:    result = opA | opB;
            corePkg::aluAnd:   result = opA & opB;
            corePkg::aluPassB: result = opB;
            default:           result = '0;
        endcase
    end

    // branch condition on its own operand pair
    always_comb begin
        case (compFunct)
            isaPkg::f3Beq:  cmpTrue = (cmpA == cmpB);
            isaPkg::f3Bne:  cmpTrue = (cmpA != cmpB);
            isaPkg::f3Blt:  cmpTrue = ($signed(cmpA) < $signed(cmpB));
            isaPkg::f3Bge:  cmpTrue = ($signed(cmpA) >= $signed(cmpB));
            isaPkg::f3Bltu: cmpTrue = (cmpA < cmpB);
            isaPkg::f3Bgeu: cmpTrue = (cmpA >= cmpB);
            default:        cmpTrue = 1'b0;
        endcase
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [4:0]               rAddr1,
    input  logic [4:0]               rAddr2,
    input  logic [4:0]               wAddr,
    input  logic [corePkg::xlen-1:0] wData,
    input  logic                     we,
    output logic [corePkg::xlen-1:0] rData1,
    output logic [corePkg::xlen-1:0] rData2
);

    // x0 has no storage
    logic [corePkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

    assign rData1 = (rAddr1 == 5'd0) ? '0 : regs[rAddr1];
    assign rData2 = (rAddr2 == 5'd0) ? '0 : regs[rAddr2];

endmodule

/* hdl/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder (
    input  logic [corePkg::xlen-1:0] inst,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    output logic [4:0]               rd,
    output logic [corePkg::xlen-1:0] imm,
    output corePkg::aluOpT           aluOp,
    output corePkg::srcASelT         srcASel,
    output corePkg::srcBSelT         srcBSel,
    output corePkg::wbSelT           wbSel,
    output logic [2:0]               compFunct,
    output logic                     isBranch,
    output logic                     isJal,
    output logic                     isJalr,
    output logic                     isLoad,
    output logic                     isStore,
    output logic                     isEbreak
);

    isaPkg::opcodeT           opcode;
    logic [2:0]               funct3;
    logic                     altBit;
    corePkg::aluOpT           functOp;
    logic [corePkg::xlen-1:0] immI;
    logic [corePkg::xlen-1:0] immS;
    logic [corePkg::xlen-1:0] immB;
    logic [corePkg::xlen-1:0] immU;
    logic [corePkg::xlen-1:0] immJ;

    assign opcode = isaPkg::opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign altBit = inst[30];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign compFunct = funct3;

    // sign-extended immediates, all formats
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 to ALU op, sub only exists in the register form
    always_comb begin
        case (funct3)
            isaPkg::f3AddSub: begin
                if (opcode == isaPkg::opReg && altBit) begin
                    functOp = corePkg::aluSub;
                end else begin
                    functOp = corePkg::aluAdd;
                end
            end
            isaPkg::f3Sll:    functOp = corePkg::aluSll;
            isaPkg::f3Slt:    functOp = corePkg::aluSlt;
            isaPkg::f3Sltu:   functOp = corePkg::aluSltu;
            isaPkg::f3Xor:    functOp = corePkg::aluXor;
            isaPkg::f3SrlSra: functOp = altBit ? corePkg::aluSra : corePkg::aluSrl;
            isaPkg::f3Or:     functOp = corePkg::aluOr;
            default:          functOp = corePkg::aluAnd;
        endcase
    end

    always_comb begin
        // defaults form a no-op
        aluOp    = corePkg::aluAdd;
        srcASel  = corePkg::srcAReg;
        srcBSel  = corePkg::srcBImm;
        wbSel    = corePkg::wbNone;
        imm      = immI;
        isBranch = 1'b0;
        isJal    = 1'b0;
        isJalr   = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isEbreak = 1'b0;
        case (opcode)
            isaPkg::opReg: begin
                aluOp   = functOp;
                srcBSel = corePkg::srcBReg;
                wbSel   = corePkg::wbAlu;
            end
            isaPkg::opImm: begin
                aluOp = functOp;
                wbSel = corePkg::wbAlu;
            end
            isaPkg::opLui: begin
                aluOp   = corePkg::aluPassB;
                srcASel = corePkg::srcAZero;
                imm     = immU;
                wbSel   = corePkg::wbAlu;
            end
            isaPkg::opAuipc: begin
                srcASel = corePkg::srcAPc;
                imm     = immU;
                wbSel   = corePkg::wbAlu;
            end
            isaPkg::opJal: begin
                srcASel = corePkg::srcAPc;
                imm     = immJ;
                wbSel   = corePkg::wbPc4;
                isJal   = 1'b1;
            end
            isaPkg::opJalr: begin
                wbSel  = corePkg::wbPc4;
                isJalr = 1'b1;
            end
            isaPkg::opBranch: begin
                // ALU forms the target, comparator sees rs1 and rs2
                srcASel  = corePkg::srcAPc;
                imm      = immB;
                isBranch = 1'b1;
            end
            isaPkg::opLoad: begin
                wbSel  = corePkg::wbLoad;
                isLoad = 1'b1;
            end
            isaPkg::opStore: begin
                imm     = immS;
                isStore = 1'b1;
            end
            isaPkg::opSystem: begin
                isEbreak = (inst == isaPkg::ebreakWord);
            end
            default: begin
                wbSel = corePkg::wbNone;
            end
        endcase
    end

endmodule

/* hdl/stageSequencer.sv */
`timescale 1ns/1ps

module stageSequencer #(
    parameter logic [corePkg::xlen-1:0] resetPc = '0
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     imemValid,
    input  logic [corePkg::xlen-1:0] imemRdata,
    input  logic                     dmemValid,
    input  logic [corePkg::xlen-1:0] dmemRdata,
    input  logic                     isBranch,
    input  logic                     isJal,
    input  logic                     isJalr,
    input  logic                     isLoad,
    input  logic                     isStore,
    input  logic                     isEbreak,
    input  corePkg::wbSelT           wbSel,
    input  logic [corePkg::xlen-1:0] aluResult,
    input  logic                     cmpTrue,
    output logic                     imemReq,
    output logic [corePkg::xlen-1:0] imemAddr,
    output logic                     dmemReq,
    output logic                     dmemWe,
    output logic [corePkg::xlen-1:0] inst,
    output logic [corePkg::xlen-1:0] pc,
    output logic                     rfWe,
    output logic [corePkg::xlen-1:0] rfWdata,
    output logic                     halted
);

    corePkg::seqStateT        state;
    corePkg::seqStateT        stateNext;
    logic [corePkg::xlen-1:0] resultQ;
    logic [corePkg::xlen-1:0] loadQ;
    logic                     takenQ;
    logic [corePkg::xlen-1:0] pcPlus4;
    logic [corePkg::xlen-1:0] nextPc;

    always_comb begin
        stateNext = state;
        case (state)
            // leave only once the request pulse has gone out
            corePkg::fetchIssue: begin
                if (imemReq) begin
                    stateNext = corePkg::fetchWait;
                end
            end
            corePkg::fetchWait: begin
                if (imemValid) begin
                    stateNext = corePkg::execute;
                end
            end
            corePkg::execute: begin
                if (isEbreak) begin
                    stateNext = corePkg::halted;
                end else if (isLoad || isStore) begin
                    stateNext = corePkg::memIssue;
                end else begin
                    stateNext = corePkg::writeback;
                end
            end
            corePkg::memIssue: begin
                stateNext = corePkg::memWait;
            end
            corePkg::memWait: begin
                if (dmemValid) begin
                    stateNext = corePkg::writeback;
                end
            end
            corePkg::writeback: begin
                stateNext = corePkg::fetchIssue;
            end
            corePkg::halted: begin
                stateNext = corePkg::halted;
            end
            default: begin
                stateNext = corePkg::fetchIssue;
            end
        endcase
    end

    // imemReq is registered so it stays low while in reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= corePkg::fetchIssue;
            imemReq <= 1'b0;
            pc      <= resetPc;
        end else begin
            state   <= stateNext;
            imemReq <= (stateNext == corePkg::fetchIssue);
            if (state == corePkg::writeback) begin
                pc <= nextPc;
            end
        end
    end

    // instruction, ALU result, branch outcome and load data
    always_ff @(posedge clk) begin
        if (state == corePkg::fetchWait && imemValid) begin
            inst <= imemRdata;
        end
        if (state == corePkg::execute) begin
            resultQ <= aluResult;
            takenQ  <= cmpTrue;
        end
        if (state == corePkg::memWait && dmemValid) begin
            loadQ <= dmemRdata;
        end
    end

    assign pcPlus4 = pc + corePkg::xlen'(4);

    // jump targets were formed by the ALU during execute
    always_comb begin
        if (isJalr) begin
            nextPc = {resultQ[corePkg::xlen-1:1], 1'b0};
        end else if (isJal || (isBranch && takenQ)) begin
            nextPc = resultQ;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_comb begin
        case (wbSel)
            corePkg::wbLoad: rfWdata = loadQ;
            corePkg::wbPc4:  rfWdata = pcPlus4;
            default:         rfWdata = resultQ;
        endcase
    end

    assign rfWe     = (state == corePkg::writeback) && (wbSel != corePkg::wbNone);
    assign imemAddr = pc;
    assign dmemReq  = (state == corePkg::memIssue);
    assign dmemWe   = (state == corePkg::memIssue) && isStore;
    assign halted   = (state == corePkg::halted);

endmodule

/* hdl/npcCore.sv */
`timescale 1ns/1ps

module npcCore #(
    parameter logic [corePkg::xlen-1:0] resetPc = '0
) (
    input  logic                     clk,
    input  logic                     rstN,
    output logic                     imemReq,
    output logic [corePkg::xlen-1:0] imemAddr,
    input  logic                     imemValid,
    input  logic [corePkg::xlen-1:0] imemRdata,
    output logic                     dmemReq,
    output logic                     dmemWe,
    output logic [corePkg::xlen-1:0] dmemAddr,
    output logic [corePkg::xlen-1:0] dmemWdata,
    input  logic                     dmemValid,
    input  logic [corePkg::xlen-1:0] dmemRdata,
    output logic                     halted
);

    logic [corePkg::xlen-1:0] inst;
    logic [corePkg::xlen-1:0] pc;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    logic [corePkg::xlen-1:0] imm;
    corePkg::aluOpT           aluOp;
    corePkg::srcASelT         srcASel;
    corePkg::srcBSelT         srcBSel;
    corePkg::wbSelT           wbSel;
    logic [2:0]               compFunct;
    logic                     isBranch;
    logic                     isJal;
    logic                     isJalr;
    logic                     isLoad;
    logic                     isStore;
    logic                     isEbreak;
    logic [corePkg::xlen-1:0] rData1;
    logic [corePkg::xlen-1:0] rData2;
    logic [corePkg::xlen-1:0] opA;
    logic [corePkg::xlen-1:0] opB;
    logic [corePkg::xlen-1:0] aluResult;
    logic                     cmpTrue;
    logic                     rfWe;
    logic [corePkg::xlen-1:0] rfWdata;

    stageSequencer #(
        .resetPc(resetPc)
    ) sequencer_i (
        .clk      (clk),
        .rstN     (rstN),
        .imemValid(imemValid),
        .imemRdata(imemRdata),
        .dmemValid(dmemValid),
        .dmemRdata(dmemRdata),
        .isBranch (isBranch),
        .isJal    (isJal),
        .isJalr   (isJalr),
        .isLoad   (isLoad),
        .isStore  (isStore),
        .isEbreak (isEbreak),
        .wbSel    (wbSel),
        .aluResult(aluResult),
        .cmpTrue  (cmpTrue),
        .imemReq  (imemReq),
        .imemAddr (imemAddr),
        .dmemReq  (dmemReq),
        .dmemWe   (dmemWe),
        .inst     (inst),
        .pc       (pc),
        .rfWe     (rfWe),
        .rfWdata  (rfWdata),
        .halted   (halted)
    );

    instDecoder decoder_i (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .aluOp    (aluOp),
        .srcASel  (srcASel),
        .srcBSel  (srcBSel),
        .wbSel    (wbSel),
        .compFunct(compFunct),
        .isBranch (isBranch),
        .isJal    (isJal),
        .isJalr   (isJalr),
        .isLoad   (isLoad),
        .isStore  (isStore),
        .isEbreak (isEbreak)
    );

    regFile regFile_i (
        .clk   (clk),
        .rstN  (rstN),
        .rAddr1(rs1),
        .rAddr2(rs2),
        .wAddr (rd),
        .wData (rfWdata),
        .we    (rfWe),
        .rData1(rData1),
        .rData2(rData2)
    );

    // operand selects in front of the ALU
    assign opA = (srcASel == corePkg::srcAReg) ? rData1 :
                 (srcASel == corePkg::srcAPc)  ? pc     : '0;
    assign opB = (srcBSel == corePkg::srcBReg) ? rData2 : imm;

    aluCompare alu_i (
        .aluOp    (aluOp),
        .compFunct(compFunct),
        .opA      (opA),
        .opB      (opB),
        .cmpA     (rData1),
        .cmpB     (rData2),
        .result   (aluResult),
        .cmpTrue  (cmpTrue)
    );

    // loads and stores address with rs1 + imm, stores send rs2
    assign dmemAddr  = aluResult;
    assign dmemWdata = rData2;

endmodule

/* verification/tbMemory.sv */
`timescale 1ns/1ps

module tbMemory #(
    parameter int          depth      = 2048,
    parameter int          maxLatency = 8,
    parameter logic [31:0] seed       = 32'hd626a16d
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        imemReq,
    input  logic [31:0] imemAddr,
    output logic        imemValid,
    output logic [31:0] imemRdata,
    input  logic        dmemReq,
    input  logic        dmemWe,
    input  logic [31:0] dmemAddr,
    input  logic [31:0] dmemWdata,
    output logic        dmemValid,
    output logic [31:0] dmemRdata
);

    // one array for code and data
    logic [31:0] words [0:depth-1];
    logic [31:0] rngState;
    int          iCount;
    int          dCount;
    logic [31:0] iAddrQ;
    logic [31:0] dAddrQ;
    logic [31:0] dDataQ;
    logic        dWeQ;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // latency in 1..maxLatency cycles
    task automatic drawLatency(output int lat);
        rngState = xorshift(rngState);
        lat      = int'(rngState % maxLatency) + 1;
    endtask

    initial begin
        rngState  = seed;
        iCount    = 0;
        dCount    = 0;
        imemValid = 1'b0;
        imemRdata = '0;
        dmemValid = 1'b0;
        dmemRdata = '0;
    end

    // responses change on the falling edge, the core samples on the rising one
    always @(negedge clk) begin
        imemValid = 1'b0;
        dmemValid = 1'b0;
        if (!rstN) begin
            iCount = 0;
            dCount = 0;
        end else begin
            if (iCount > 0) begin
                iCount--;
                if (iCount == 0) begin
                    imemValid = 1'b1;
                    imemRdata = words[(iAddrQ >> 2) % depth];
                end
            end
            if (dCount > 0) begin
                dCount--;
                if (dCount == 0) begin
                    dmemValid = 1'b1;
                    if (dWeQ) begin
                        words[(dAddrQ >> 2) % depth] = dDataQ;
                    end else begin
                        dmemRdata = words[(dAddrQ >> 2) % depth];
                    end
                end
            end
            // new requests, counted from the next falling edge
            if (imemReq) begin
                iAddrQ = imemAddr;
                drawLatency(iCount);
            end
            if (dmemReq) begin
                dAddrQ = dmemAddr;
                dDataQ = dmemWdata;
                dWeQ   = dmemWe;
                drawLatency(dCount);
            end
        end
    end

endmodule

/* verification/npcTb.sv */
`timescale 1ns/1ps

module npcTb;

    localparam logic [31:0] resetPc     = 32'h0000_0100;
    localparam logic [31:0] dataBase    = 32'h0000_1000;
    localparam int          dataWords   = 32;
    localparam int          memDepth    = 2048;
    localparam int          maxLatency  = 8;
    localparam int          resetCycles = 10;
    localparam int          idleCycles  = 50;
    localparam int          numTests    = 6;
    localparam int          instPerTest = 40;
    // fetch and data wait at worst latency plus the fixed states
    localparam int          cycleLimit  =
        numTests * (resetCycles + idleCycles + instPerTest * (2 * maxLatency + 6));

    logic        clk;
    logic        rstN;
    logic        imemReq;
    logic [31:0] imemAddr;
    logic        imemValid;
    logic [31:0] imemRdata;
    logic        dmemReq;
    logic        dmemWe;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic        dmemValid;
    logic [31:0] dmemRdata;
    logic        halted;

    logic [31:0] pcNext;
    logic [31:0] expImage [0:dataWords-1];
    string       testName;
    int          cycles;

    npcCore #(
        .resetPc(resetPc)
    ) dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .imemReq  (imemReq),
        .imemAddr (imemAddr),
        .imemValid(imemValid),
        .imemRdata(imemRdata),
        .dmemReq  (dmemReq),
        .dmemWe   (dmemWe),
        .dmemAddr (dmemAddr),
        .dmemWdata(dmemWdata),
        .dmemValid(dmemValid),
        .dmemRdata(dmemRdata),
        .halted   (halted)
    );

    tbMemory #(
        .depth     (memDepth),
        .maxLatency(maxLatency),
        .seed      (32'hd626a16d)
    ) mem_i (
        .clk      (clk),
        .rstN     (rstN),
        .imemReq  (imemReq),
        .imemAddr (imemAddr),
        .imemValid(imemValid),
        .imemRdata(imemRdata),
        .dmemReq  (dmemReq),
        .dmemWe   (dmemWe),
        .dmemAddr (dmemAddr),
        .dmemWdata(dmemWdata),
        .dmemValid(dmemValid),
        .dmemRdata(dmemRdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout after %0d cycles in test %s, core never halted", cycles, testName);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    // instruction formats
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, isaPkg::opReg};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], isaPkg::opStore};
    endfunction

    function automatic logic [31:0] bType(input logic [31:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], isaPkg::opBranch};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, isaPkg::opJal};
    endfunction

    // background pattern, every address gets its own word
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    task automatic put(input logic [31:0] word);
        mem_i.words[pcNext >> 2] = word;
        pcNext += 4;
    endtask

    task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        put(iType(imm, rs1, isaPkg::f3AddSub, rd, isaPkg::opImm));
    endtask

    task automatic lw(input logic [4:0] rd, input int slot);
        put(iType(12'(slot * 4), 5'd3, 3'b010, rd, isaPkg::opLoad));
    endtask

    task automatic br(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                      input logic [31:0] off);
        put(bType(off, rs2, rs1, f3));
    endtask

    // sw rs2 into a data slot and note what should land there
    task automatic storeCheck(input logic [4:0] rs2, input int slot, input logic [31:0] value);
        put(sType(12'(slot * 4), rs2, 5'd3));
        expImage[slot] = value;
    endtask

    task automatic regOp(input logic [6:0] f7, input logic [2:0] f3, input int slot,
                         input logic [31:0] expected);
        put(rType(f7, 5'd2, 5'd1, f3, 5'd10));
        storeCheck(5'd10, slot, expected);
    endtask

    task automatic immOp(input logic [2:0] f3, input logic [11:0] imm, input int slot,
                         input logic [31:0] expected);
        put(iType(imm, 5'd1, f3, 5'd10, isaPkg::opImm));
        storeCheck(5'd10, slot, expected);
    endtask

    // hold reset, clear memory, start the program with x3 = data base
    task automatic startTest(input string name);
        @(negedge clk);
        rstN     = 1'b0;
        testName = name;
        for (int a = 0; a < memDepth; a++) begin
            mem_i.words[a] = fillWord(a * 4);
        end
        for (int s = 0; s < dataWords; s++) begin
            expImage[s] = fillWord(dataBase + s * 4);
        end
        pcNext = resetPc;
        put(uType(dataBase[31:12], 5'd3, isaPkg::opLui));
    endtask

    task automatic checkImage();
        logic [31:0] addr;
        logic [31:0] got;
        for (int s = 0; s < dataWords; s++) begin
            addr = dataBase + s * 4;
            got  = mem_i.words[addr >> 2];
            assert (got === expImage[s]) else begin
                $display("FAILED at %0t ns in %s: mem[0x%h] expected %h actual %h",
                         $time, testName, addr, expImage[s], got);
                $display("TEST RESULT: FAIL");
                $fatal(1, "data memory mismatch");
            end
        end
    endtask

    task automatic runProgram();
        repeat (resetCycles) @(negedge clk);
        assert (!imemReq && !dmemReq && !dmemWe && !halted) else begin
            $display("core outputs were not idle during reset in test %s", testName);
            $display("TEST RESULT: FAIL");
            $fatal(1, "reset state wrong");
        end
        rstN = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        checkImage();
    endtask

    task automatic aluOps();
        logic [31:0] a;
        logic [31:0] b;
        a = 32'hffff_ffec;
        b = 32'd7;
        startTest("alu");
        addi(5'd1, 5'd0, 12'hfec);
        addi(5'd2, 5'd0, 12'd7);
        regOp(7'h00, isaPkg::f3AddSub, 0, a + b);
        regOp(7'h20, isaPkg::f3AddSub, 1, a - b);
        regOp(7'h00, isaPkg::f3Sll, 2, a << b[4:0]);
        regOp(7'h00, isaPkg::f3Slt, 3, {31'b0, $signed(a) < $signed(b)});
        regOp(7'h00, isaPkg::f3Sltu, 4, {31'b0, a < b});
        regOp(7'h00, isaPkg::f3Xor, 5, a ^ b);
        regOp(7'h00, isaPkg::f3SrlSra, 6, a >> b[4:0]);
        regOp(7'h20, isaPkg::f3SrlSra, 7, $signed(a) >>> b[4:0]);
        regOp(7'h00, isaPkg::f3Or, 8, a | b);
        regOp(7'h00, isaPkg::f3And, 9, a & b);
        immOp(isaPkg::f3Slt, 12'hffb, 10, {31'b0, $signed(a) < -5});
        immOp(isaPkg::f3Sltu, 12'h005, 11, {31'b0, a < 32'd5});
        immOp(isaPkg::f3Xor, 12'h0f0, 12, a ^ 32'h0000_00f0);
        immOp(isaPkg::f3Sll, 12'h004, 13, a << 4);
        // imm bit 10 set selects srai
        immOp(isaPkg::f3SrlSra, 12'h403, 14, $signed(a) >>> 3);
        immOp(isaPkg::f3SrlSra, 12'h01f, 15, a >> 31);
        put(isaPkg::ebreakWord);
        runProgram();
    endtask

    task automatic upperImm();
        logic [31:0] expected;
        startTest("lui auipc");
        put(uType(20'habcde, 5'd4, isaPkg::opLui));
        storeCheck(5'd4, 0, 32'habcd_e000);
        expected = 32'h1234_5000 + pcNext;
        put(uType(20'h12345, 5'd5, isaPkg::opAuipc));
        storeCheck(5'd5, 1, expected);
        expected = 32'hffff_f000 + pcNext;
        put(uType(20'hfffff, 5'd6, isaPkg::opAuipc));
        storeCheck(5'd6, 2, expected);
        put(isaPkg::ebreakWord);
        runProgram();
    endtask

    // x8 counts fall-through paths, x9 counts paths that a taken branch skips
    task automatic branchLoop();
        int          loopCount;
        logic [31:0] loopPc;
        loopCount = 3;
        startTest("branches");
        addi(5'd6, 5'd0, 12'(loopCount));
        addi(5'd7, 5'd0, 12'hfff);
        loopPc = pcNext;
        addi(5'd5, 5'd5, 12'd1);
        br(isaPkg::f3Blt, 5'd7, 5'd5, 8);
        addi(5'd9, 5'd9, 12'd1);
        br(isaPkg::f3Bltu, 5'd7, 5'd5, 8);
        addi(5'd8, 5'd8, 12'd1);
        br(isaPkg::f3Bge, 5'd5, 5'd7, 8);
        addi(5'd9, 5'd9, 12'd1);
        br(isaPkg::f3Bgeu, 5'd5, 5'd7, 8);
        addi(5'd8, 5'd8, 12'd1);
        br(isaPkg::f3Beq, 5'd5, 5'd0, 8);
        addi(5'd8, 5'd8, 12'd1);
        addi(5'd0, 5'd5, 12'd0);
        br(isaPkg::f3Bne, 5'd5, 5'd6, loopPc - pcNext);
        // past the loop, the opposite outcomes
        br(isaPkg::f3Bltu, 5'd5, 5'd7, 8);
        addi(5'd9, 5'd9, 12'd1);
        br(isaPkg::f3Bgeu, 5'd7, 5'd5, 8);
        addi(5'd9, 5'd9, 12'd1);
        br(isaPkg::f3Blt, 5'd5, 5'd7, 8);
        addi(5'd8, 5'd8, 12'd1);
        br(isaPkg::f3Bge, 5'd7, 5'd5, 8);
        addi(5'd8, 5'd8, 12'd1);
        br(isaPkg::f3Beq, 5'd5, 5'd6, 8);
        addi(5'd9, 5'd9, 12'd1);
        storeCheck(5'd5, 0, loopCount);
        storeCheck(5'd8, 1, 3 * loopCount + 2);
        storeCheck(5'd9, 2, 32'd0);
        storeCheck(5'd0, 3, 32'd0);
        put(isaPkg::ebreakWord);
        runProgram();
    endtask

    task automatic jumps();
        logic [31:0] jalPc;
        logic [31:0] basePc;
        startTest("jal jalr");
        jalPc = pcNext;
        put(jType(32'd12, 5'd1));
        put(sType(12'd16, 5'd3, 5'd3));
        put(sType(12'd20, 5'd3, 5'd3));
        storeCheck(5'd1, 0, jalPc + 4);
        basePc = pcNext;
        put(uType(20'h0, 5'd11, isaPkg::opAuipc));
        // odd offset, target bit 0 is dropped
        put(iType(12'd17, 5'd11, 3'b000, 5'd2, isaPkg::opJalr));
        put(sType(12'd24, 5'd3, 5'd3));
        put(sType(12'd28, 5'd3, 5'd3));
        // pc seen at the target
        put(uType(20'h0, 5'd12, isaPkg::opAuipc));
        storeCheck(5'd12, 3, (basePc + 32'd17) & ~32'd1);
        storeCheck(5'd2, 1, basePc + 8);
        storeCheck(5'd11, 2, basePc);
        put(isaPkg::ebreakWord);
        runProgram();
    endtask

    task automatic loadStore();
        startTest("load store");
        lw(5'd1, 16);
        lw(5'd2, 17);
        put(rType(7'h00, 5'd2, 5'd1, isaPkg::f3AddSub, 5'd4));
        storeCheck(5'd4, 0, expImage[16] + expImage[17]);
        storeCheck(5'd1, 1, expImage[16]);
        addi(5'd5, 5'd0, 12'h123);
        storeCheck(5'd5, 2, 32'h0000_0123);
        lw(5'd6, 2);
        put(iType(12'hfff, 5'd6, isaPkg::f3Xor, 5'd6, isaPkg::opImm));
        storeCheck(5'd6, 3, ~32'h0000_0123);
        lw(5'd7, 0);
        storeCheck(5'd7, 18, expImage[0]);
        storeCheck(5'd2, 16, expImage[17]);
        put(isaPkg::ebreakWord);
        runProgram();
    endtask

    task automatic ebreakHalt();
        startTest("ebreak");
        addi(5'd1, 5'd0, 12'd5);
        storeCheck(5'd1, 0, 32'd5);
        put(isaPkg::ebreakWord);
        // never reached
        put(sType(12'd4, 5'd1, 5'd3));
        runProgram();
        repeat (idleCycles) begin
            @(negedge clk);
            assert (!imemReq && halted) else begin
                $display("core fetched or left halted after EBREAK at %0t ns", $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "fetch after halt");
            end
        end
        checkImage();
    endtask

    initial begin
        rstN     = 1'b0;
        cycles   = 0;
        testName = "none";
        aluOps();
        upperImm();
        branchLoop();
        jumps();
        loadStore();
        ebreakHalt();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
common/isaPkg.sv
common/corePkg.sv
hdl/aluCompare.sv
hdl/regFile.sv
hdl/instDecoder.sv
hdl/stageSequencer.sv
hdl/npcCore.sv
verification/tbMemory.sv
verification/npcTb.sv
